// ==== source/emu_pkg.sv ====
package emu_pkg;

    // Host bus
    localparam int addr_w = 10;
    localparam int data_w = 32;

    // Emulated design resources
    localparam int trig_count  = 32;
    localparam int reset_count = 32;
    localparam int ff_count    = 8;
    localparam int ff_width    = 64;
    localparam int cnt_w       = 64;

    // Each chain word is seen by the host as two data words
    localparam int buf_words = ff_count * ff_width / data_w;
    localparam int idx_w     = $clog2(buf_words);
    localparam int ff_idx_w  = $clog2(ff_count);

    // Register word addresses
    localparam logic [addr_w-1:0] run_ctrl_addr    = 10'h000;
    localparam logic [addr_w-1:0] tick_step_addr   = 10'h001;
    localparam logic [addr_w-1:0] tick_cnt_lo_addr = 10'h002;
    localparam logic [addr_w-1:0] tick_cnt_hi_addr = 10'h003;
    localparam logic [addr_w-1:0] scan_ctrl_addr   = 10'h004;
    localparam logic [addr_w-1:0] trig_stat_addr   = 10'h040;
    localparam logic [addr_w-1:0] trig_en_addr     = 10'h044;
    localparam logic [addr_w-1:0] reset_ctrl_addr  = 10'h048;
    localparam logic [addr_w-1:0] scan_buf_base    = 10'h080;

    typedef struct packed {
        logic              wen;
        logic              ren;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
    } host_req_t;

    // One-hot register target
    typedef struct packed {
        logic run;
        logic step;
        logic cnt_lo;
        logic cnt_hi;
        logic scan;
        logic trig_stat;
        logic trig_en;
        logic reset;
        logic scan_buf;
    } reg_sel_t;

    typedef struct packed {
        logic              wen;
        reg_sel_t          sel;
        logic [idx_w-1:0]  index;
        logic [data_w-1:0] wdata;
    } reg_wr_t;

    typedef struct packed {
        logic             ren;
        reg_sel_t         sel;
        logic [idx_w-1:0] index;
    } reg_rd_t;

endpackage

// ==== source/host_port.sv ====
`timescale 1ns/1ps

module host_port (
    input  logic                       host_clk,
    input  logic                       host_rst,
    input  logic                       wen,
    input  logic                       ren,
    input  logic [emu_pkg::addr_w-1:0] addr,
    input  logic [emu_pkg::data_w-1:0] wdata,
    output emu_pkg::reg_wr_t           reg_wr,
    output emu_pkg::reg_rd_t           reg_rd,
    input  logic [emu_pkg::data_w-1:0] run_rdata,
    input  logic [emu_pkg::data_w-1:0] trig_rdata,
    input  logic [emu_pkg::data_w-1:0] scan_rdata,
    output logic [emu_pkg::data_w-1:0] rdata,
    output logic                       rdata_valid
);
    import emu_pkg::*;

    host_req_t         req_q;
    reg_sel_t          sel;
    logic [data_w-1:0] rd_word;

    // Address decode, unmapped words give an all-zero select
    function automatic reg_sel_t decode(input logic [addr_w-1:0] a);
        reg_sel_t s;
        s           = '0;
        s.run       = (a == run_ctrl_addr);
        s.step      = (a == tick_step_addr);
        s.cnt_lo    = (a == tick_cnt_lo_addr);
        s.cnt_hi    = (a == tick_cnt_hi_addr);
        s.scan      = (a == scan_ctrl_addr);
        s.trig_stat = (a == trig_stat_addr);
        s.trig_en   = (a == trig_en_addr);
        s.reset     = (a == reset_ctrl_addr);
        s.scan_buf  = (a >= scan_buf_base) && (a < scan_buf_base + addr_w'(buf_words));
        return s;
    endfunction

    // Request stage
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            req_q <= '0;
        end else begin
            req_q.wen   <= wen;
            req_q.ren   <= ren;
            req_q.addr  <= addr;
            req_q.wdata <= wdata;
        end
    end

    assign sel = decode(req_q.addr);

    always_comb begin
        reg_wr.wen   = req_q.wen;
        reg_wr.sel   = sel;
        reg_wr.index = req_q.addr[idx_w-1:0];
        reg_wr.wdata = req_q.wdata;
        reg_rd.ren   = req_q.ren;
        reg_rd.sel   = sel;
        reg_rd.index = req_q.addr[idx_w-1:0];
    end

    // Pick the word from the stage that owns the address
    always_comb begin
        rd_word = '0;
        if (reg_rd.sel.run || reg_rd.sel.step || reg_rd.sel.cnt_lo || reg_rd.sel.cnt_hi) begin
            rd_word = run_rdata;
        end else if (reg_rd.sel.trig_stat || reg_rd.sel.trig_en || reg_rd.sel.reset) begin
            rd_word = trig_rdata;
        end else if (reg_rd.sel.scan || reg_rd.sel.scan_buf) begin
            rd_word = scan_rdata;
        end
    end

    // Response stage
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            rdata       <= '0;
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= reg_rd.ren;
            if (reg_rd.ren) begin
                rdata <= rd_word;
            end
        end
    end

endmodule

// ==== source/run_ctrl.sv ====
`timescale 1ns/1ps

module run_ctrl (
    input  logic                       host_clk,
    input  logic                       host_rst,
    input  emu_pkg::reg_wr_t           reg_wr,
    input  emu_pkg::reg_rd_t           reg_rd,
    input  logic                       tick,
    input  logic                       trig_active,
    output logic                       run_mode,
    output logic                       scan_mode,
    output logic [emu_pkg::data_w-1:0] run_rdata
);
    import emu_pkg::*;

    logic              resume_req;
    logic [data_w-1:0] tick_step;
    logic [cnt_w-1:0]  tick_cnt;
    logic              run_wr;
    logic              step_last;
    logic              pause_now;

    assign run_wr    = reg_wr.wen && reg_wr.sel.run;
    assign step_last = (tick_step == data_w'(1));

    // Any of these stops the run on the current tick, which is still counted
    assign pause_now = tick && (!resume_req || trig_active || step_last);

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            resume_req <= 1'b0;
            scan_mode  <= 1'b0;
        end else if (run_wr) begin
            resume_req <= reg_wr.wdata[0];
            scan_mode  <= reg_wr.wdata[1];
        end
    end

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            run_mode <= 1'b0;
        end else if (run_mode) begin
            if (pause_now) begin
                run_mode <= 1'b0;
            end
        end else if (run_wr && reg_wr.wdata[0]) begin
            run_mode <= 1'b1;
        end
    end

    // Step count runs down only while running, host loads it while paused
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            tick_step <= '0;
        end else if (run_mode) begin
            if (tick && tick_step != '0) begin
                tick_step <= tick_step - data_w'(1);
            end
        end else if (reg_wr.wen && reg_wr.sel.step) begin
            tick_step <= reg_wr.wdata;
        end
    end

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            tick_cnt <= '0;
        end else if (run_mode) begin
            if (tick) begin
                tick_cnt <= tick_cnt + cnt_w'(1);
            end
        end else if (reg_wr.wen && reg_wr.sel.cnt_lo) begin
            tick_cnt[data_w-1:0] <= reg_wr.wdata;
        end else if (reg_wr.wen && reg_wr.sel.cnt_hi) begin
            tick_cnt[cnt_w-1:data_w] <= reg_wr.wdata;
        end
    end

    always_comb begin
        run_rdata = '0;
        if (reg_rd.sel.run) begin
            run_rdata = {{(data_w-2){1'b0}}, scan_mode, run_mode};
        end else if (reg_rd.sel.step) begin
            run_rdata = tick_step;
        end else if (reg_rd.sel.cnt_lo) begin
            run_rdata = tick_cnt[data_w-1:0];
        end else if (reg_rd.sel.cnt_hi) begin
            run_rdata = tick_cnt[cnt_w-1:data_w];
        end
    end

endmodule

// ==== source/trig_reset_regs.sv ====
`timescale 1ns/1ps

module trig_reset_regs (
    input  logic                            host_clk,
    input  logic                            host_rst,
    input  emu_pkg::reg_wr_t                reg_wr,
    input  emu_pkg::reg_rd_t                reg_rd,
    input  logic                            run_mode,
    input  logic [emu_pkg::trig_count-1:0]  trig,
    output logic                            trig_active,
    output logic [emu_pkg::reset_count-1:0] rst,
    output logic [emu_pkg::data_w-1:0]      trig_rdata
);
    import emu_pkg::*;

    logic [trig_count-1:0] trig_stat;
    logic [trig_count-1:0] trig_en;

    // Status follows the inputs while running and freezes on pause
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            trig_stat <= '0;
        end else if (run_mode) begin
            trig_stat <= trig;
        end
    end

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            trig_en <= '0;
        end else if (reg_wr.wen && reg_wr.sel.trig_en) begin
            trig_en <= reg_wr.wdata[trig_count-1:0];
        end
    end

    // Reset word goes straight out to the emulated design
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            rst <= '0;
        end else if (reg_wr.wen && reg_wr.sel.reset) begin
            rst <= reg_wr.wdata[reset_count-1:0];
        end
    end

    assign trig_active = |(trig & trig_en);

    always_comb begin
        trig_rdata = '0;
        if (reg_rd.sel.trig_stat) begin
            trig_rdata = data_w'(trig_stat);
        end else if (reg_rd.sel.trig_en) begin
            trig_rdata = data_w'(trig_en);
        end else if (reg_rd.sel.reset) begin
            trig_rdata = data_w'(rst);
        end
    end

endmodule

// ==== source/scan_chain_ctrl.sv ====
`timescale 1ns/1ps

module scan_chain_ctrl (
    input  logic                         host_clk,
    input  logic                         host_rst,
    input  emu_pkg::reg_wr_t             reg_wr,
    input  emu_pkg::reg_rd_t             reg_rd,
    output logic                         ff_se,
    output logic [emu_pkg::ff_width-1:0] ff_di,
    input  logic [emu_pkg::ff_width-1:0] ff_do,
    output logic [emu_pkg::data_w-1:0]   scan_rdata
);
    import emu_pkg::*;

    logic [ff_width-1:0] scan_buf [ff_count];
    logic                running;
    logic [ff_idx_w-1:0] word_cnt;
    logic                start;
    logic                buf_wr;
    logic [ff_idx_w-1:0] wr_word;
    logic [ff_idx_w-1:0] rd_word;
    logic                wr_hi;
    logic                rd_hi;

    // Host index bit 0 picks the half, the rest picks the chain word
    assign wr_word = reg_wr.index[idx_w-1:1];
    assign wr_hi   = reg_wr.index[0];
    assign rd_word = reg_rd.index[idx_w-1:1];
    assign rd_hi   = reg_rd.index[0];

    // Start and buffer writes are only taken while idle
    assign start  = reg_wr.wen && reg_wr.sel.scan && reg_wr.wdata[0] && !running;
    assign buf_wr = reg_wr.wen && reg_wr.sel.scan_buf && !running;

    // Sequencer walks word 0 upward, one word per cycle
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            running  <= 1'b0;
            word_cnt <= '0;
        end else if (running) begin
            if (word_cnt == ff_idx_w'(ff_count - 1)) begin
                running  <= 1'b0;
                word_cnt <= '0;
            end else begin
                word_cnt <= word_cnt + ff_idx_w'(1);
            end
        end else if (start) begin
            running  <= 1'b1;
            word_cnt <= '0;
        end
    end

    // Swap: buffer word goes out on ff_di while the chain word comes back
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            for (int i = 0; i < ff_count; i++) begin
                scan_buf[i] <= '0;
            end
        end else if (running) begin
            scan_buf[word_cnt] <= ff_do;
        end else if (buf_wr) begin
            if (wr_hi) begin
                scan_buf[wr_word][ff_width-1:data_w] <= reg_wr.wdata;
            end else begin
                scan_buf[wr_word][data_w-1:0] <= reg_wr.wdata;
            end
        end
    end

    assign ff_se = running;
    assign ff_di = scan_buf[word_cnt];

    always_comb begin
        scan_rdata = '0;
        if (reg_rd.sel.scan) begin
            scan_rdata = data_w'(running);
        end else if (reg_rd.sel.scan_buf) begin
            if (rd_hi) begin
                scan_rdata = scan_buf[rd_word][ff_width-1:data_w];
            end else begin
                scan_rdata = scan_buf[rd_word][data_w-1:0];
            end
        end
    end

endmodule

// ==== source/emu_ctrl.sv ====
`timescale 1ns/1ps

module emu_ctrl (
    input  logic                            host_clk,
    input  logic                            host_rst,
    input  logic                            wen,
    input  logic                            ren,
    input  logic [emu_pkg::addr_w-1:0]      addr,
    input  logic [emu_pkg::data_w-1:0]      wdata,
    output logic [emu_pkg::data_w-1:0]      rdata,
    output logic                            rdata_valid,
    input  logic                            tick,
    input  logic [emu_pkg::trig_count-1:0]  trig,
    output logic                            run_mode,
    output logic                            scan_mode,
    output logic [emu_pkg::reset_count-1:0] rst,
    output logic                            ff_se,
    output logic [emu_pkg::ff_width-1:0]    ff_di,
    input  logic [emu_pkg::ff_width-1:0]    ff_do
);
    import emu_pkg::*;

    reg_wr_t           reg_wr;
    reg_rd_t           reg_rd;
    logic [data_w-1:0] run_rdata;
    logic [data_w-1:0] trig_rdata;
    logic [data_w-1:0] scan_rdata;
    logic              trig_active;

    // Request decode and read response
    host_port i_host_port (
        .host_clk    (host_clk),
        .host_rst    (host_rst),
        .wen         (wen),
        .ren         (ren),
        .addr        (addr),
        .wdata       (wdata),
        .reg_wr      (reg_wr),
        .reg_rd      (reg_rd),
        .run_rdata   (run_rdata),
        .trig_rdata  (trig_rdata),
        .scan_rdata  (scan_rdata),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    run_ctrl i_run_ctrl (
        .host_clk    (host_clk),
        .host_rst    (host_rst),
        .reg_wr      (reg_wr),
        .reg_rd      (reg_rd),
        .tick        (tick),
        .trig_active (trig_active),
        .run_mode    (run_mode),
        .scan_mode   (scan_mode),
        .run_rdata   (run_rdata)
    );

    trig_reset_regs i_trig_reset_regs (
        .host_clk    (host_clk),
        .host_rst    (host_rst),
        .reg_wr      (reg_wr),
        .reg_rd      (reg_rd),
        .run_mode    (run_mode),
        .trig        (trig),
        .trig_active (trig_active),
        .rst         (rst),
        .trig_rdata  (trig_rdata)
    );

    scan_chain_ctrl i_scan_chain_ctrl (
        .host_clk   (host_clk),
        .host_rst   (host_rst),
        .reg_wr     (reg_wr),
        .reg_rd     (reg_rd),
        .ff_se      (ff_se),
        .ff_di      (ff_di),
        .ff_do      (ff_do),
        .scan_rdata (scan_rdata)
    );

endmodule

// ==== verif/emu_ctrl_tb.sv ====
`timescale 1ns/1ps

module emu_ctrl_tb;
    import emu_pkg::*;

    logic                   host_clk = 1'b0;
    logic                   host_rst;
    logic                   wen;
    logic                   ren;
    logic [addr_w-1:0]      addr;
    logic [data_w-1:0]      wdata;
    logic [data_w-1:0]      rdata;
    logic                   rdata_valid;
    logic                   tick;
    logic [trig_count-1:0]  trig;
    logic                   run_mode;
    logic                   scan_mode;
    logic [reset_count-1:0] rst;
    logic                   ff_se;
    logic [ff_width-1:0]    ff_di;
    logic [ff_width-1:0]    ff_do;

    // Chain model state
    logic [ff_width-1:0] chain [ff_count];
    logic [ff_width-1:0] got [ff_count];
    logic [3:0]          k;
    int                  se_cycles;

    int errors = 0;
    int test_errors = 0;
    int checks = 0;
    int run_ticks = 0;
    bit timed_out = 1'b0;

    emu_ctrl i_emu_ctrl (
        .host_clk    (host_clk),
        .host_rst    (host_rst),
        .wen         (wen),
        .ren         (ren),
        .addr        (addr),
        .wdata       (wdata),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .tick        (tick),
        .trig        (trig),
        .run_mode    (run_mode),
        .scan_mode   (scan_mode),
        .rst         (rst),
        .ff_se       (ff_se),
        .ff_di       (ff_di),
        .ff_do       (ff_do)
    );

    always #5 host_clk = ~host_clk;

    // Emulated chain answers word k and keeps what it was sent
    assign ff_do = chain[k[2:0]];

    always @(posedge host_clk) begin
        if (host_rst) begin
            k         <= '0;
            se_cycles <= 0;
        end else if (ff_se) begin
            got[k[2:0]] <= ff_di;
            k           <= k + 4'd1;
            se_cycles   <= se_cycles + 1;
        end else begin
            k <= '0;
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("Error at %0d ns: %s expected %0h, got %0h",
                     $time, name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic note_timeout(input string what);
        $display("Timeout at %0d ns: %s", $time, what);
        errors++;
        test_errors++;
        timed_out = 1'b1;
    endtask

    task automatic report_test(input int num);
        if (test_errors == 0) begin
            $display("Test %0d passed", num);
        end else begin
            $display("Test %0d failed with %0d errors", num, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic host_write(input logic [31:0] a, input logic [31:0] d);
        @(posedge host_clk);
        wen   <= 1'b1;
        addr  <= a[addr_w-1:0];
        wdata <= d;
        @(posedge host_clk);
        wen <= 1'b0;
    endtask

    task automatic host_read(input logic [31:0] a, output logic [31:0] d);
        int waited;
        @(posedge host_clk);
        ren  <= 1'b1;
        addr <= a[addr_w-1:0];
        @(posedge host_clk);
        ren <= 1'b0;
        waited = 0;
        d = '0;
        @(negedge host_clk);
        while (!rdata_valid && waited < 10) begin
            @(negedge host_clk);
            waited++;
        end
        if (rdata_valid) begin
            d = rdata;
        end else begin
            note_timeout($sformatf("no read response for address %0h", a));
        end
    endtask

    // Count of 0 picks a random count and ticks seen while running are tallied
    task automatic drive_ticks(input int n, input logic mode);
        int count;
        count = (n == 0) ? 1 + int'($urandom % 32'd32) : n;
        for (int i = 0; i < count; i++) begin
            @(posedge host_clk);
            tick <= 1'b1;
            @(negedge host_clk);
            if (run_mode) begin
                run_ticks++;
            end
            @(posedge host_clk);
            tick <= 1'b0;
        end
        @(negedge host_clk);
        check_value("run_mode", 64'(mode), 64'(run_mode));
    endtask

    task automatic wait_run_mode(input int limit, input logic mode);
        int waited;
        waited = 0;
        @(negedge host_clk);
        while (run_mode !== mode && waited < limit) begin
            @(negedge host_clk);
            waited++;
        end
        if (run_mode !== mode) begin
            note_timeout("run_mode did not reach the expected state");
        end
    endtask

    task automatic check_tick_count(input logic [31:0] base);
        logic [31:0] word;
        logic [63:0] cnt;
        host_read(32'(tick_cnt_lo_addr), word);
        cnt[31:0] = word;
        host_read(32'(tick_cnt_hi_addr), word);
        cnt[63:32] = word;
        check_value("tick_cnt", 64'(base) + 64'(run_ticks), cnt);
        run_ticks = 0;
    endtask

    // Bit 1 of the run word is the scan mode flag and leaves on its own port
    task automatic exercise_scan_mode();
        logic [31:0] word;
        host_write(32'(run_ctrl_addr), 32'h2);
        host_read(32'(run_ctrl_addr), word);
        check_value("run_ctrl word", 64'h2, 64'(word));
        check_value("scan_mode", 64'h1, 64'(scan_mode));
        host_write(32'(run_ctrl_addr), 32'h0);
        repeat (2) @(negedge host_clk);
        check_value("scan_mode", 64'h0, 64'(scan_mode));
    endtask

    function automatic logic [31:0] fill_word(input logic [31:0] base, input logic [31:0] a);
        return base ^ (a * 32'h0001_0001);
    endfunction

    task automatic run_scan(input int n, input logic [31:0] base);
        logic [31:0] loaded [2*ff_count];
        logic [31:0] lo;
        logic [31:0] hi;
        int          se_start;
        int          polls;
        for (int i = 0; i < 2 * ff_count; i++) begin
            loaded[i] = fill_word(base, 32'(scan_buf_base) + 32'(i));
            host_write(32'(scan_buf_base) + 32'(i), loaded[i]);
        end
        se_start = se_cycles;
        host_write(32'(scan_ctrl_addr), 32'h1);
        polls = 0;
        lo = 32'h1;
        while (lo[0] && polls < 20 && !timed_out) begin
            host_read(32'(scan_ctrl_addr), lo);
            polls++;
        end
        if (lo[0]) begin
            note_timeout("scan running bit did not clear");
        end
        check_value("ff_se cycles", 64'(n), 64'(se_cycles - se_start));
        for (int w = 0; w < ff_count; w++) begin
            host_read(32'(scan_buf_base) + 32'(2 * w), lo);
            host_read(32'(scan_buf_base) + 32'(2 * w + 1), hi);
            check_value($sformatf("scan_buf word %0d", w), chain[w], {hi, lo});
            check_value($sformatf("ff_di word %0d", w), {loaded[2*w+1], loaded[2*w]}, got[w]);
        end
    endtask

    initial begin
        int              fd;
        int              n;
        logic [63:0]     op;
        logic [8*128-1:0] line;
        logic [31:0]     a;
        logic [31:0]     d;
        logic [31:0]     word;
        host_rst = 1'b1;
        wen      = 1'b0;
        ren      = 1'b0;
        addr     = '0;
        wdata    = '0;
        tick     = 1'b0;
        trig     = '0;
        void'($urandom(32'h895c66b1));
        for (int i = 0; i < ff_count; i++) begin
            chain[i] = {$urandom(), $urandom()};
        end
        repeat (10) @(posedge host_clk);
        host_rst <= 1'b0;

        fd = $fopen("verif/emu_ctrl_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file verif/emu_ctrl_patterns.txt");
            errors++;
        end else begin
            while (!timed_out && $fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s %h %h", op, a, d);
                if (n == 3 && op != 64'("#")) begin
                    case (op)
                        64'("write"): host_write(a, d);
                        64'("read"): begin
                            host_read(a, word);
                            check_value($sformatf("rdata at %03h", a), 64'(d), 64'(word));
                            // Reset word is also visible on the rst port
                            if (a == 32'(reset_ctrl_addr)) begin
                                check_value("rst", 64'(d), 64'(rst));
                            end
                            if (a == 32'(run_ctrl_addr)) begin
                                check_value("scan_mode", 64'(d[1]), 64'(scan_mode));
                            end
                        end
                        64'("ticks"): drive_ticks(int'(a), d[0]);
                        64'("trig"): begin
                            @(posedge host_clk);
                            trig <= d | ($urandom & a);
                        end
                        64'("wait"): wait_run_mode(int'(a), d[0]);
                        64'("count"): check_tick_count(a);
                        64'("scan"): run_scan(int'(a), d);
                        64'("done"): report_test(int'(a));
                        default: begin
                            $display("Unknown operation in the pattern file: %0s", op);
                            errors++;
                        end
                    endcase
                end
            end
            $fclose(fd);
            if (!timed_out) begin
                exercise_scan_mode();
                report_test(6);
            end
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verif/emu_ctrl_patterns.txt ====
# op addr_or_count data_or_expected (hex), ops: write read ticks trig wait count scan done
# ticks n mode drives n ticks (0 random) then expects run_mode, trig mask word adds noise
# Test 1 reset values, readback, rst port, unmapped words
read 000 00000000
read 001 00000000
read 002 00000000
read 004 00000000
read 040 00000000
read 048 00000000
read 08f 00000000
write 001 0000abcd
write 002 12345678
write 003 9abcdef0
write 044 00ff00ff
write 048 a5a55a5a
read 001 0000abcd
read 002 12345678
read 003 9abcdef0
read 044 00ff00ff
read 048 a5a55a5a
write 3ff 11111111
read 3ff 00000000
write 044 00000000
write 001 00000000
done 1 0
# Test 2 free run, paused ticks and counter writes while running
write 002 00000100
write 003 00000000
ticks 2 0
write 000 00000001
wait 10 1
ticks 0 1
write 002 00000000
write 003 ffffffff
ticks 0 1
write 000 00000000
ticks 1 0
ticks 3 0
count 100 0
done 2 0
# Test 3 step of five ticks
write 002 00000000
write 001 00000005
write 000 00000001
wait 10 1
ticks 4 1
ticks 1 0
ticks 2 0
read 001 00000000
read 002 00000005
done 3 0
# Test 4 disabled trigger noise, enabled trigger pauses
write 044 00000100
trig ff 0
write 000 00000001
wait 10 1
ticks 3 1
trig 0 100
ticks 1 0
trig 0 0
read 040 00000100
done 4 0
# Test 5 scan swap
scan 8 c0de0000
done 5 0

// ==== all.f ====
source/emu_pkg.sv
source/host_port.sv
source/run_ctrl.sv
source/trig_reset_regs.sv
source/scan_chain_ctrl.sv
source/emu_ctrl.sv
verif/emu_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the emu_ctrl testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module emu_ctrl_tb -f all.f > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/Vemu_ctrl_tb > sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation completed successfully" sim.log || exit 1
echo "Run passed"
exit 0
